//--- logic/div_types_pkg.sv
`default_nettype none

package div_types_pkg;

    // Destination register file index width
    parameter int ADDR_W = 5;

    // Wide enough to hold a bit position or a step count from 0 to 32
    parameter int STEP_W = 6;

    typedef logic [ADDR_W-1:0] reg_addr_t;

    // Remaining iterations, or a leading-one position inside an operand
    typedef logic [STEP_W-1:0] step_cnt_t;

endpackage : div_types_pkg

`default_nettype wire

//--- logic/div_op_pkg.sv
`default_nettype none

package div_op_pkg;

    // Which half of the division is written back
    typedef enum logic {
        DIV_QUOT = 1'b0,
        DIV_REM  = 1'b1
    } div_kind_e;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,  // Waiting for an issue
        ST_ITER   = 2'd1,  // One restoring step per cycle
        ST_FINISH = 2'd2   // Hand the result to the writeback register
    } ctrl_state_e;

endpackage : div_op_pkg

`default_nettype wire

//--- logic/div_step_if.sv
`default_nettype none

interface div_step_if #(
    parameter int DATA_W = 32
);

    logic                      load;       // Capture operands and align the divisor
    logic                      step;       // Perform one compare and subtract
    div_types_pkg::step_cnt_t  shift_amt;  // Left shift applied to the divisor on load

    logic [DATA_W-1:0]         quotient_mag;
    logic [DATA_W-1:0]         remainder_mag;

    modport ctrl (
        output load,
        output step,
        output shift_amt
    );

    modport dp (
        input  load,
        input  step,
        input  shift_amt,
        output quotient_mag,
        output remainder_mag
    );

endinterface : div_step_if

`default_nettype wire

//--- logic/div_operand_prep.sv
`default_nettype none

module div_operand_prep #(
    parameter int DATA_W = 32
) (
    input  wire logic [DATA_W-1:0]       dividend,
    input  wire logic [DATA_W-1:0]       divisor,
    input  wire logic                    is_signed,

    output logic [DATA_W-1:0]            dividend_mag,
    output logic [DATA_W-1:0]            divisor_mag,
    output logic                         dividend_neg,
    output logic                         divisor_neg,
    output div_types_pkg::step_cnt_t     shift_amt,
    output div_types_pkg::step_cnt_t     step_count,
    output logic                         div_by_zero,
    output logic                         too_small
);

    div_types_pkg::step_cnt_t dividend_lead;
    div_types_pkg::step_cnt_t divisor_lead;

    // Index of the highest set bit where an all-zero vector gives zero
    function automatic div_types_pkg::step_cnt_t lead_one(input logic [DATA_W-1:0] v);
        div_types_pkg::step_cnt_t pos;
        pos = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (v[i]) begin
                pos = div_types_pkg::step_cnt_t'(i);
            end
        end
        return pos;
    endfunction

    assign dividend_neg = is_signed & dividend[DATA_W-1];
    assign divisor_neg  = is_signed & divisor[DATA_W-1];

    // The most negative value maps to 2**(DATA_W-1), which still fits unsigned
    assign dividend_mag = dividend_neg ? (~dividend + 1'b1) : dividend;
    assign divisor_mag  = divisor_neg ? (~divisor + 1'b1) : divisor;

    assign dividend_lead = lead_one(dividend_mag);
    assign divisor_lead  = lead_one(divisor_mag);

    assign div_by_zero = (divisor_mag == '0);

    always_comb begin
        too_small = 1'b0;
        if (!div_by_zero) begin
            too_small = (dividend_mag == '0) || (dividend_lead < divisor_lead);
        end
    end

    // Only meaningful when neither early-out flag is set
    assign shift_amt  = dividend_lead - divisor_lead;
    assign step_count = shift_amt + 1'b1;

endmodule : div_operand_prep

`default_nettype wire

//--- logic/div_shift_sub.sv
`default_nettype none

module div_shift_sub #(
    parameter int DATA_W = 32
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic [DATA_W-1:0]  dividend_mag,
    input  wire logic [DATA_W-1:0]  divisor_mag,
    div_step_if.dp                  step_if
);

    logic [DATA_W-1:0] rem_q;   // Partial remainder
    logic [DATA_W-1:0] dvs_q;   // Aligned divisor that moves right one bit per step
    logic [DATA_W-1:0] quo_q;
    logic              fits;

    assign fits = (rem_q >= dvs_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rem_q <= '0;
            dvs_q <= '0;
            quo_q <= '0;
        end else if (step_if.load) begin
            rem_q <= dividend_mag;
            dvs_q <= divisor_mag << step_if.shift_amt;  // Leading ones now line up
            quo_q <= '0;
        end else if (step_if.step) begin
            if (fits) begin
                rem_q <= rem_q - dvs_q;
            end
            quo_q <= {quo_q[DATA_W-2:0], fits};
            dvs_q <= dvs_q >> 1;
        end
    end

    assign step_if.quotient_mag  = quo_q;
    assign step_if.remainder_mag = rem_q;

endmodule : div_shift_sub

`default_nettype wire

//--- logic/div_ctrl.sv
`default_nettype none

module div_ctrl (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       issue_valid,
    input  wire div_op_pkg::div_kind_e      issue_kind,
    input  wire div_types_pkg::reg_addr_t   issue_dest,
    input  wire logic                       dividend_neg,
    input  wire logic                       divisor_neg,
    input  wire logic                       div_by_zero,
    input  wire logic                       too_small,
    input  wire div_types_pkg::step_cnt_t   step_count,
    input  wire div_types_pkg::step_cnt_t   shift_amt,

    output logic                            busy,
    output logic                            capture,
    output logic                            bypass,
    output div_op_pkg::div_kind_e           kind,
    output logic                            quot_neg,
    output logic                            rem_neg,
    output div_types_pkg::reg_addr_t        dest,
    div_step_if.ctrl                        step_if
);

    div_op_pkg::ctrl_state_e   state;
    div_types_pkg::step_cnt_t  cnt_q;
    div_op_pkg::div_kind_e     kind_q;
    div_types_pkg::reg_addr_t  dest_q;
    logic                      accept;
    logic                      early;

    assign accept = issue_valid && (state == div_op_pkg::ST_IDLE);
    assign early  = div_by_zero || too_small;
    assign busy   = (state != div_op_pkg::ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= div_op_pkg::ST_IDLE;
            cnt_q    <= '0;
            kind_q   <= div_op_pkg::DIV_QUOT;
            dest_q   <= '0;
            quot_neg <= 1'b0;
            rem_neg  <= 1'b0;
        end else begin
            case (state)
                div_op_pkg::ST_IDLE: begin
                    if (issue_valid) begin
                        kind_q   <= issue_kind;
                        dest_q   <= issue_dest;
                        quot_neg <= dividend_neg ^ divisor_neg;
                        rem_neg  <= dividend_neg;  // Remainder follows the dividend
                        if (!early) begin
                            cnt_q <= step_count;
                            state <= div_op_pkg::ST_ITER;
                        end
                    end
                end
                div_op_pkg::ST_ITER: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == div_types_pkg::step_cnt_t'(1)) begin
                        state <= div_op_pkg::ST_FINISH;
                    end
                end
                div_op_pkg::ST_FINISH: state <= div_op_pkg::ST_IDLE;
                default: state <= div_op_pkg::ST_IDLE;
            endcase
        end
    end

    // Early outs are written back straight from the issue, so pass it through
    always_comb begin
        if (accept) begin
            kind = issue_kind;
            dest = issue_dest;
        end else begin
            kind = kind_q;
            dest = dest_q;
        end
    end

    assign bypass  = accept && early;
    assign capture = bypass || (state == div_op_pkg::ST_FINISH);

    assign step_if.load      = accept && !early;
    assign step_if.step      = (state == div_op_pkg::ST_ITER);
    assign step_if.shift_amt = shift_amt;

endmodule : div_ctrl

`default_nettype wire

//--- logic/div_result_fix.sv
`default_nettype none

module div_result_fix #(
    parameter int DATA_W = 32
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       capture,
    input  wire logic                       bypass,
    input  wire div_op_pkg::div_kind_e      kind,
    input  wire logic                       quot_neg,
    input  wire logic                       rem_neg,
    input  wire div_types_pkg::reg_addr_t   dest,
    input  wire logic [DATA_W-1:0]          quotient_mag,
    input  wire logic [DATA_W-1:0]          remainder_mag,
    input  wire logic [DATA_W-1:0]          bypass_dividend,
    input  wire logic [DATA_W-1:0]          bypass_zero_div,

    output logic                            result_valid,
    output logic [DATA_W-1:0]               result,
    output div_types_pkg::reg_addr_t        result_dest
);

    logic [DATA_W-1:0] quot_signed;
    logic [DATA_W-1:0] rem_signed;
    logic [DATA_W-1:0] next_result;

    assign quot_signed = quot_neg ? (~quotient_mag + 1'b1) : quotient_mag;
    assign rem_signed  = rem_neg ? (~remainder_mag + 1'b1) : remainder_mag;

    always_comb begin
        if (bypass) begin
            // Quotient is all ones on zero divisor and zero when too small
            next_result = (kind == div_op_pkg::DIV_REM) ? bypass_dividend : bypass_zero_div;
        end else begin
            next_result = (kind == div_op_pkg::DIV_REM) ? rem_signed : quot_signed;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= capture;  // Single cycle writeback pulse
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            result      <= next_result;
            result_dest <= dest;
        end
    end

endmodule : div_result_fix

`default_nettype wire

//--- logic/div_unit.sv
`default_nettype none

module div_unit #(
    parameter int DATA_W = 32
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       issue_valid,
    input  wire div_op_pkg::div_kind_e      issue_kind,
    input  wire logic                       is_signed,
    input  wire logic [DATA_W-1:0]          dividend,
    input  wire logic [DATA_W-1:0]          divisor,
    input  wire div_types_pkg::reg_addr_t   issue_dest,

    output logic                            busy,
    output logic                            result_valid,
    output logic [DATA_W-1:0]               result,
    output div_types_pkg::reg_addr_t        result_dest
);

    logic [DATA_W-1:0]         dividend_mag;
    logic [DATA_W-1:0]         divisor_mag;
    logic                      dividend_neg;
    logic                      divisor_neg;
    div_types_pkg::step_cnt_t  shift_amt;
    div_types_pkg::step_cnt_t  step_count;
    logic                      div_by_zero;
    logic                      too_small;
    logic                      capture;
    logic                      bypass;
    div_op_pkg::div_kind_e     kind;
    logic                      quot_neg;
    logic                      rem_neg;
    div_types_pkg::reg_addr_t  dest;

    div_step_if #(.DATA_W(DATA_W)) step_if ();

    div_operand_prep #(.DATA_W(DATA_W)) u_prep (
        .dividend     (dividend),
        .divisor      (divisor),
        .is_signed    (is_signed),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .shift_amt    (shift_amt),
        .step_count   (step_count),
        .div_by_zero  (div_by_zero),
        .too_small    (too_small)
    );

    div_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_kind   (issue_kind),
        .issue_dest   (issue_dest),
        .dividend_neg (dividend_neg),
        .divisor_neg  (divisor_neg),
        .div_by_zero  (div_by_zero),
        .too_small    (too_small),
        .step_count   (step_count),
        .shift_amt    (shift_amt),
        .busy         (busy),
        .capture      (capture),
        .bypass       (bypass),
        .kind         (kind),
        .quot_neg     (quot_neg),
        .rem_neg      (rem_neg),
        .dest         (dest),
        .step_if      (step_if.ctrl)
    );

    div_shift_sub #(.DATA_W(DATA_W)) u_shift_sub (
        .clk          (clk),
        .rst_n        (rst_n),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .step_if      (step_if.dp)
    );

    // Early outs take the raw dividend as the remainder
    div_result_fix #(.DATA_W(DATA_W)) u_result_fix (
        .clk             (clk),
        .rst_n           (rst_n),
        .capture         (capture),
        .bypass          (bypass),
        .kind            (kind),
        .quot_neg        (quot_neg),
        .rem_neg         (rem_neg),
        .dest            (dest),
        .quotient_mag    (step_if.quotient_mag),
        .remainder_mag   (step_if.remainder_mag),
        .bypass_dividend (dividend),
        .bypass_zero_div ({DATA_W{div_by_zero}}),
        .result_valid    (result_valid),
        .result          (result),
        .result_dest     (result_dest)
    );

endmodule : div_unit

`default_nettype wire

//--- bench/div_unit_tb.sv
`default_nettype none

module div_unit_tb;

    localparam int DATA_W        = 32;
    localparam int CLK_PERIOD    = 40;
    localparam int NUM_RANDOM    = 400;
    localparam int NUM_DIRECTED  = 21;
    localparam int CYCLES_PER_OP = 40;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      issue_valid;
    div_op_pkg::div_kind_e     issue_kind;
    logic                      is_signed;
    logic [DATA_W-1:0]         dividend;
    logic [DATA_W-1:0]         divisor;
    div_types_pkg::reg_addr_t  issue_dest;
    logic                      busy;
    logic                      result_valid;
    logic [DATA_W-1:0]         result;
    div_types_pkg::reg_addr_t  result_dest;

    integer      seed        = 32'h656d_cab3;
    int unsigned cycle       = 0;
    int          error_count = 0;

    // Expected writebacks with the oldest at the front
    logic [DATA_W-1:0]         exp_value_q[$];
    div_types_pkg::reg_addr_t  exp_dest_q[$];
    int unsigned               exp_edges_q[$];
    int unsigned               issue_cycle_q[$];

    div_unit #(.DATA_W(DATA_W)) dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_kind   (issue_kind),
        .is_signed    (is_signed),
        .dividend     (dividend),
        .divisor      (divisor),
        .issue_dest   (issue_dest),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result),
        .result_dest  (result_dest)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // Number of significant bits in an unsigned value
    function automatic int bit_length(input logic [DATA_W-1:0] v);
        int n;
        n = 0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (v[i] && n == 0) begin
                n = i + 1;
            end
        end
        return n;
    endfunction

    function automatic logic [DATA_W-1:0] magnitude(input logic sgn, input logic [DATA_W-1:0] v);
        if (sgn && v[DATA_W-1]) begin
            return -v;
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] ref_div(
        input div_op_pkg::div_kind_e kind,
        input logic                  sgn,
        input logic [DATA_W-1:0]     a,
        input logic [DATA_W-1:0]     b
    );
        logic [DATA_W-1:0] am;
        logic [DATA_W-1:0] bm;
        logic [DATA_W-1:0] q;
        logic [DATA_W-1:0] r;
        logic              a_neg;
        logic              b_neg;
        a_neg = sgn && a[DATA_W-1];
        b_neg = sgn && b[DATA_W-1];
        am = magnitude(sgn, a);
        bm = magnitude(sgn, b);
        if (bm == '0) begin
            q = '1;  // Zero divisor keeps the dividend as remainder
            r = a;
        end else begin
            q = am / bm;
            r = am % bm;
            if (a_neg != b_neg) begin
                q = -q;
            end
            if (a_neg) begin
                r = -r;
            end
        end
        return (kind == div_op_pkg::DIV_REM) ? r : q;
    endfunction

    // Edges from the driving edge of the request to the edge that raises result_valid
    function automatic int unsigned expected_edges(input logic sgn,
                                                   input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        int la;
        int lb;
        la = bit_length(magnitude(sgn, a));
        lb = bit_length(magnitude(sgn, b));
        if (lb == 0 || la < lb) begin
            return 1;
        end
        return la - lb + 3;  // Load, one step per quotient bit, writeback register
    endfunction

    task automatic stop_on_failure();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string what, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // Starts and ends a short delay after a rising edge
    task automatic issue_op(input div_op_pkg::div_kind_e kind, input logic sgn,
                            input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                            input div_types_pkg::reg_addr_t dest);
        logic        accepted;
        int unsigned acc_cycle;
        issue_valid = 1'b1;
        issue_kind  = kind;
        is_signed   = sgn;
        dividend    = a;
        divisor     = b;
        issue_dest  = dest;
        accepted    = 1'b0;
        acc_cycle   = 0;
        // The request stays on the inputs until it meets an idle unit
        while (!accepted) begin
            @(negedge clk);
            accepted  = !busy;
            acc_cycle = cycle;
            @(posedge clk);
        end
        #2;
        issue_valid = 1'b0;
        exp_value_q.push_back(ref_div(kind, sgn, a, b));
        exp_dest_q.push_back(dest);
        exp_edges_q.push_back(expected_edges(sgn, a, b));
        issue_cycle_q.push_back(acc_cycle);
    endtask

    always @(negedge clk) begin : compare_results
        logic exp_busy;
        if (rst_n) begin
            exp_busy = 1'b0;
            if (exp_value_q.size() > 0) begin
                exp_busy = (cycle > issue_cycle_q[0])
                           && (cycle < issue_cycle_q[0] + exp_edges_q[0]);
            end
            check_value("busy", busy, exp_busy);
            if (result_valid) begin
                if (exp_value_q.size() == 0) begin
                    $display("A result was written back at %0t with nothing outstanding", $time);
                    stop_on_failure();
                end else begin
                    check_value("result", result, exp_value_q[0]);
                    check_value("result_dest", result_dest, exp_dest_q[0]);
                    check_value("latency in edges", cycle - issue_cycle_q[0], exp_edges_q[0]);
                    void'(exp_value_q.pop_front());
                    void'(exp_dest_q.pop_front());
                    void'(exp_edges_q.pop_front());
                    void'(issue_cycle_q.pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        #(CLK_PERIOD * (CYCLES_PER_OP * (NUM_RANDOM + NUM_DIRECTED) + 200));
        $display("Timeout: the run hung with %0d results outstanding", exp_value_q.size());
        stop_on_failure();
    end

    initial begin : stimulus
        div_op_pkg::div_kind_e kind;
        logic                  sgn;
        logic [DATA_W-1:0]     a;
        logic [DATA_W-1:0]     b;
        logic [31:0]           rnd;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_kind  = div_op_pkg::DIV_QUOT;
        is_signed   = 1'b0;
        dividend    = '0;
        divisor     = '0;
        issue_dest  = '0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        // Division by zero
        issue_op(div_op_pkg::DIV_QUOT, 1'b0, 123, 0, 5'd1);
        issue_op(div_op_pkg::DIV_REM,  1'b0, 123, 0, 5'd2);
        issue_op(div_op_pkg::DIV_QUOT, 1'b1, -5, 0, 5'd3);
        issue_op(div_op_pkg::DIV_REM,  1'b1, -5, 0, 5'd4);
        // Dividend with fewer bits than the divisor
        issue_op(div_op_pkg::DIV_QUOT, 1'b0, 3, 100, 5'd5);
        issue_op(div_op_pkg::DIV_REM,  1'b0, 3, 100, 5'd6);
        issue_op(div_op_pkg::DIV_REM,  1'b1, -3, 100, 5'd7);
        issue_op(div_op_pkg::DIV_QUOT, 1'b0, 0, 7, 5'd8);
        // Signed corners
        issue_op(div_op_pkg::DIV_QUOT, 1'b1, 32'h8000_0000, 32'hffff_ffff, 5'd9);
        issue_op(div_op_pkg::DIV_REM,  1'b1, 32'h8000_0000, 32'hffff_ffff, 5'd10);
        issue_op(div_op_pkg::DIV_QUOT, 1'b1, -100, 7, 5'd11);
        issue_op(div_op_pkg::DIV_REM,  1'b1, -100, 7, 5'd12);
        issue_op(div_op_pkg::DIV_QUOT, 1'b1, 100, -7, 5'd13);
        issue_op(div_op_pkg::DIV_REM,  1'b1, 100, -7, 5'd14);
        issue_op(div_op_pkg::DIV_QUOT, 1'b1, -100, -7, 5'd15);
        issue_op(div_op_pkg::DIV_REM,  1'b1, -100, -7, 5'd16);
        // Longest and shortest iteration counts
        issue_op(div_op_pkg::DIV_QUOT, 1'b0, 32'hffff_ffff, 1, 5'd17);
        issue_op(div_op_pkg::DIV_REM,  1'b0, 32'hffff_ffff, 1, 5'd18);
        issue_op(div_op_pkg::DIV_QUOT, 1'b0, 10, 9, 5'd19);
        issue_op(div_op_pkg::DIV_REM,  1'b1, 32'h8000_0000, 1, 5'd20);
        issue_op(div_op_pkg::DIV_QUOT, 1'b1, 32'h8000_0000, 32'h8000_0000, 5'd21);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            a   = $random(seed);
            b   = $random(seed);
            b   = b >> rnd[4:0];  // Spread the quotient lengths
            if (rnd[9:5] == 5'd0) begin
                b = '0;
            end
            if (rnd[14:10] == 5'd0) begin
                a = a >> rnd[19:15];
            end
            kind = rnd[20] ? div_op_pkg::DIV_REM : div_op_pkg::DIV_QUOT;
            sgn  = rnd[21];
            issue_op(kind, sgn, a, b, rnd[26:22]);
        end

        while (exp_value_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);  // A stray writeback would show up here
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : div_unit_tb

`default_nettype wire

//--- vlog.f
logic/div_types_pkg.sv
logic/div_op_pkg.sv
logic/div_step_if.sv
logic/div_operand_prep.sv
logic/div_shift_sub.sv
logic/div_ctrl.sv
logic/div_result_fix.sv
logic/div_unit.sv
bench/div_unit_tb.sv

//--- Makefile
# Verilator build and run for the divide unit testbench

TOP = div_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir sim.log
